//--- eeprom_pkg.sv
package eeprom_pkg;

    // 24C16 style: page in 10..8, byte in 7..0
    typedef logic [10:0] eeprom_addr_t;

    // host request, taken in the cycle of the wr or rd strobe
    typedef struct packed {
        eeprom_addr_t addr;
        logic [7:0]   data;
    } eeprom_req_t;

    // finished transaction
    typedef struct packed {
        logic [7:0] data;   // read data, only meaningful after a read
        logic       nack;   // slave withheld an ACK, transaction aborted
    } eeprom_result_t;

    // one operation of the bit engine
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,   // byte out, ACK sampled
        OP_READ     // byte in, answered with NACK
    } bit_op_e;

    // device type code in the upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

//--- i2c_clock_gen.sv
`timescale 1ns/100ps

module i2c_clock_gen #(
    parameter int SCL_HALF = 4
) (
    input  logic CLK,
    input  logic RESET,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CW = $clog2(SCL_HALF);
    localparam logic [CW-1:0] LAST = CW'(SCL_HALF - 1);
    localparam logic [CW-1:0] MID  = CW'(SCL_HALF / 2);

    logic [CW-1:0] cnt;

    // free running, scl high out of reset
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cnt <= '0;
            scl <= 1'b1;
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;
            scl <= ~scl;
        end
        else
        begin
            cnt <= cnt + CW'(1);
        end
    end

    assign low_mid  = ~scl && (cnt == MID);
    assign high_mid = scl && (cnt == MID);

    // high strobe a half later, never together with the low one
    strobes_apart: assert property (@(posedge CLK) disable iff (RESET)
        low_mid |-> ##SCL_HALF (high_mid && !low_mid));

    // strobe lands mid-half, counted from the scl edge
    low_mid_in_low: assert property (@(posedge CLK) disable iff (RESET)
        $fell(scl) |-> ##(SCL_HALF / 2) low_mid);

    high_mid_in_high: assert property (@(posedge CLK) disable iff (RESET)
        $rose(scl) |-> ##(SCL_HALF / 2) high_mid);

endmodule

//--- i2c_bit_engine.sv
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               scl,
    input  logic               low_mid,
    input  logic               high_mid,
    input  logic               op_go,
    input  eeprom_pkg::bit_op_e op,
    input  logic [7:0]         op_byte,
    input  logic               sda_in,
    output logic               sda_oe,
    output logic               op_done,
    output logic [7:0]         rx_byte,
    output logic               ack_ok
);

    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        E_IDLE,
        E_LOW,      // waiting for low_mid
        E_HIGH      // waiting for high_mid
    } eng_state_e;

    eng_state_e state;
    bit_op_e    op_q;
    logic [7:0] shreg;
    logic [3:0] bit_cnt;
    logic       at_low;
    logic       at_high;
    logic       last_period;

    assign at_low  = (state == E_LOW) && low_mid;
    assign at_high = (state == E_HIGH) && high_mid;

    // start and stop take one scl period, bytes take nine
    assign last_period = (op_q == OP_START) || (op_q == OP_STOP) || (bit_cnt == 4'd8);

    assign rx_byte = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= E_IDLE;
            op_q    <= OP_STOP;
            bit_cnt <= '0;
            sda_oe  <= 1'b0;
            op_done <= 1'b0;
            ack_ok  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            case (state)
                E_IDLE:
                begin
                    if (op_go)
                    begin
                        op_q    <= op;
                        bit_cnt <= '0;
                        state   <= E_LOW;
                    end
                end
                E_LOW:
                begin
                    if (at_low)
                    begin
                        case (op_q)
                            OP_START: sda_oe <= 1'b0;
                            OP_STOP:  sda_oe <= 1'b1;
                            OP_WRITE: sda_oe <= (bit_cnt == 4'd8) ? 1'b0 : ~shreg[7];
                            default:  sda_oe <= 1'b0;  // read bits, then NACK
                        endcase
                        state <= E_HIGH;
                    end
                end
                E_HIGH:
                begin
                    if (at_high)
                    begin
                        case (op_q)
                            OP_START: sda_oe <= 1'b1;  // sda falls with scl high
                            OP_STOP:  sda_oe <= 1'b0;  // sda rises with scl high
                            OP_WRITE:
                            begin
                                if (bit_cnt == 4'd8)
                                    ack_ok <= ~sda_in;
                            end
                            default: ;
                        endcase
                        if (last_period)
                        begin
                            op_done <= 1'b1;
                            state   <= E_IDLE;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            state   <= E_LOW;
                        end
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // msb first both ways
    always_ff @(posedge CLK)
    begin
        if ((state == E_IDLE) && op_go)
            shreg <= op_byte;
        else if (at_low && (op_q == OP_WRITE))
            shreg <= {shreg[6:0], 1'b0};
        else if (at_high && (op_q == OP_READ) && (bit_cnt != 4'd8))
            shreg <= {shreg[6:0], sda_in};
    end

    go_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        op_go |-> (state == E_IDLE));

    // data moves in the low half, only start and stop touch sda with scl high
    sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $changed(sda_oe)) |-> (op_q inside {OP_START, OP_STOP}));

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/100ps

module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  eeprom_pkg::eeprom_req_t   req,
    input  logic                      op_done,
    input  logic [7:0]                rx_byte,
    input  logic                      ack_ok,
    output logic                      op_go,
    output eeprom_pkg::bit_op_e       op,
    output logic [7:0]                op_byte,
    output logic                      busy,
    output logic                      done,
    output eeprom_pkg::eeprom_result_t result
);

    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_WR_START,
        S_CTRL_WR,
        S_ADDR_WR,
        S_DATA_WR,
        S_RD_START,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_FINISH
    } seq_state_e;

    seq_state_e  state;
    eeprom_req_t req_q;
    logic        is_rd;
    logic        accept;
    logic        abort;

    // device code, page bits, r/w
    function automatic logic [7:0] ctrl_byte(input eeprom_addr_t addr, input logic rw);
        return {DEVICE_CODE, addr[10:8], rw};
    endfunction

    assign accept = (state == S_IDLE) && (wr || rd);

    // any byte out that was not acknowledged
    assign abort = op_done && !ack_ok &&
                   (state inside {S_CTRL_WR, S_ADDR_WR, S_DATA_WR, S_CTRL_RD});

    always_ff @(posedge CLK)
    begin
        if (accept)
            req_q <= req;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            is_rd   <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            op_go   <= 1'b0;
            op      <= OP_STOP;
            op_byte <= '0;
            result  <= '0;
        end
        else
        begin
            op_go <= 1'b0;
            done  <= 1'b0;
            if (abort)
            begin
                result.nack <= 1'b1;
                op_go       <= 1'b1;
                op          <= OP_STOP;
                state       <= S_STOP;
            end
            else
            begin
                case (state)
                    S_IDLE:
                    begin
                        if (accept)
                        begin
                            is_rd       <= rd && !wr;  // write wins
                            busy        <= 1'b1;
                            result.nack <= 1'b0;
                            op_go       <= 1'b1;
                            op          <= OP_START;
                            state       <= S_WR_START;
                        end
                    end
                    S_WR_START:
                    begin
                        if (op_done)
                        begin
                            op_go   <= 1'b1;
                            op      <= OP_WRITE;
                            op_byte <= ctrl_byte(req_q.addr, 1'b0);
                            state   <= S_CTRL_WR;
                        end
                    end
                    S_CTRL_WR:
                    begin
                        if (op_done)
                        begin
                            op_go   <= 1'b1;
                            op      <= OP_WRITE;
                            op_byte <= req_q.addr[7:0];
                            state   <= S_ADDR_WR;
                        end
                    end
                    S_ADDR_WR:
                    begin
                        if (op_done && is_rd)
                        begin
                            op_go <= 1'b1;
                            op    <= OP_START;  // repeated start
                            state <= S_RD_START;
                        end
                        else if (op_done)
                        begin
                            op_go   <= 1'b1;
                            op      <= OP_WRITE;
                            op_byte <= req_q.data;
                            state   <= S_DATA_WR;
                        end
                    end
                    S_RD_START:
                    begin
                        if (op_done)
                        begin
                            op_go   <= 1'b1;
                            op      <= OP_WRITE;
                            op_byte <= ctrl_byte(req_q.addr, 1'b1);
                            state   <= S_CTRL_RD;
                        end
                    end
                    S_CTRL_RD:
                    begin
                        if (op_done)
                        begin
                            op_go <= 1'b1;
                            op    <= OP_READ;
                            state <= S_DATA_RD;
                        end
                    end
                    S_DATA_WR, S_DATA_RD:
                    begin
                        if (op_done)
                        begin
                            if (state == S_DATA_RD)
                                result.data <= rx_byte;
                            op_go <= 1'b1;
                            op    <= OP_STOP;
                            state <= S_STOP;
                        end
                    end
                    S_STOP:
                    begin
                        if (op_done)
                            state <= S_FINISH;
                    end
                    S_FINISH:
                    begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done);

    done_after_busy: assert property (@(posedge CLK) disable iff (RESET)
        done |-> $past(busy));

endmodule

//--- eeprom_ctrl_top.sv
`timescale 1ns/100ps

module eeprom_ctrl_top #(
    parameter int SCL_HALF = 4
) (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  eeprom_pkg::eeprom_req_t   req,
    output logic                      busy,
    output logic                      done,
    output eeprom_pkg::eeprom_result_t result,
    output logic                      scl,
    output logic                      sda_oe,
    input  logic                      sda_in
);

    import eeprom_pkg::*;

    logic       low_mid;
    logic       high_mid;
    logic       op_go;
    bit_op_e    op;
    logic [7:0] op_byte;
    logic       op_done;
    logic [7:0] rx_byte;
    logic       ack_ok;

    i2c_clock_gen #(
        .SCL_HALF (SCL_HALF)
    ) clock_gen_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    i2c_bit_engine bit_engine_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid),
        .op_go    (op_go),
        .op       (op),
        .op_byte  (op_byte),
        .sda_in   (sda_in),
        .sda_oe   (sda_oe),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_ok   (ack_ok)
    );

    eeprom_sequencer sequencer_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .req      (req),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_ok   (ack_ok),
        .op_go    (op_go),
        .op       (op),
        .op_byte  (op_byte),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

endmodule

//--- tb_eeprom_model.sv
`timescale 1ns/100ps

module tb_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic absent,    // withhold every ACK
    output logic sda_oe
);

    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_READ,
        M_IGNORE    // wait for the next start or stop
    } model_state_e;

    logic [7:0]   mem [0:2047];
    model_state_e state;
    model_state_e next_state;   // taken when the ack slot ends
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   shreg;
    logic [7:0]   tx_byte;
    logic [3:0]   bit_cnt;
    logic         ack_slot;
    logic [2:0]   page;
    logic [7:0]   word_addr;
    logic         filled = 1'b0;
    logic         scl_rise;
    logic         scl_fall;
    logic         start_seen;
    logic         stop_seen;

    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign start_seen = scl && scl_q && sda_q && !sda;
    assign stop_seen  = scl && scl_q && !sda_q && sda;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            state      <= M_IDLE;
            next_state <= M_IDLE;
            bit_cnt    <= '0;
            ack_slot   <= 1'b0;
            sda_oe     <= 1'b0;
            page       <= '0;
            word_addr  <= '0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            if (!filled)
            begin
                for (int a = 0; a < 2048; a++)
                    mem[a] <= 8'($urandom);
                filled <= 1'b1;
            end
        end
        else if (start_seen)
        begin
            state    <= M_CTRL;
            bit_cnt  <= '0;
            ack_slot <= 1'b0;
            sda_oe   <= 1'b0;
        end
        else if (stop_seen)
        begin
            state    <= M_IDLE;
            ack_slot <= 1'b0;
            sda_oe   <= 1'b0;
        end
        else if (state == M_READ)
        begin
            if (scl_rise && (bit_cnt == 4'd8))
                state <= M_IGNORE;  // master NACK, single byte only
            else if (scl_rise)
                bit_cnt <= bit_cnt + 4'd1;
            else if (scl_fall && (bit_cnt == 4'd8))
                sda_oe <= 1'b0;
            else if (scl_fall)
            begin
                sda_oe  <= !tx_byte[7];
                tx_byte <= {tx_byte[6:0], 1'b0};
            end
        end
        else if (state inside {M_CTRL, M_ADDR, M_DATA})
        begin
            if (scl_rise && !ack_slot && (bit_cnt < 4'd8))
            begin
                shreg   <= {shreg[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (scl_fall && ack_slot)
            begin
                ack_slot <= 1'b0;
                bit_cnt  <= '0;
                sda_oe   <= 1'b0;
                state    <= next_state;
                if (next_state == M_READ)
                begin
                    sda_oe  <= !mem[{page, word_addr}][7];   // msb goes out at once
                    tx_byte <= {mem[{page, word_addr}][6:0], 1'b0};
                end
            end
            else if (scl_fall && (bit_cnt == 4'd8))
            begin
                ack_slot <= 1'b1;
                case (state)
                    M_CTRL:
                    begin
                        if (shreg[7:4] == DEVICE_CODE)
                        begin
                            sda_oe     <= !absent;
                            page       <= shreg[3:1];
                            if (shreg[0])
                                next_state <= absent ? M_IGNORE : M_READ;
                            else
                                next_state <= M_ADDR;
                        end
                        else
                        begin
                            sda_oe     <= 1'b0;
                            next_state <= M_IGNORE;
                        end
                    end
                    M_ADDR:
                    begin
                        sda_oe     <= !absent;
                        word_addr  <= shreg;
                        next_state <= M_DATA;
                    end
                    default:
                    begin
                        // bytes still decoded with the ack withheld
                        mem[{page, word_addr}] <= shreg;
                        sda_oe     <= !absent;
                        next_state <= M_IGNORE;  // no page writes
                    end
                endcase
            end
        end
    end

endmodule

//--- tb_eeprom_ctrl.sv
`timescale 1ns/100ps

module tb_eeprom_ctrl;

    import eeprom_pkg::*;

    localparam int SCL_HALF = 4;
    localparam int N_WRITES = 60;
    localparam int N_READS  = 60;
    localparam int MAX_WAIT = 400 * 2 * SCL_HALF;   // 400 scl periods

    logic           CLK;
    logic           RESET;
    logic           wr;
    logic           rd;
    eeprom_req_t    req;
    logic           busy;
    logic           done;
    eeprom_result_t result;
    logic           scl;
    logic           sda_oe;
    logic           model_oe;
    logic           sda;
    logic           absent;
    logic [7:0]     ref_mem [0:2047];

    assign sda = !(sda_oe || model_oe);  // wired open drain

    eeprom_ctrl_top #(
        .SCL_HALF (SCL_HALF)
    ) eeprom_ctrl_top_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda)
    );

    tb_eeprom_model eeprom_model_i (
        .CLK    (CLK),
        .RESET  (RESET),
        .scl    (scl),
        .sda    (sda),
        .absent (absent),
        .sda_oe (model_oe)
    );

    always #2 CLK = ~CLK;

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // data only compared after a read that was acknowledged
    task automatic check_result(input eeprom_result_t got, input eeprom_result_t exp,
                                input logic with_data);
        if ((got.nack !== exp.nack) || (with_data && (got.data !== exp.data)))
        begin
            $display("FAIL result got %h expected %h", got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic run_request(input logic is_read, input eeprom_addr_t addr,
                               input logic [7:0] data, input logic no_ack,
                               output eeprom_result_t res);
        int cycles;
        int stray_at;
        cycles   = 0;
        stray_at = 2 + int'($urandom % 200);
        absent   = no_ack;
        req.addr = addr;
        req.data = data;
        wr       = !is_read;
        rd       = is_read;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_bit("busy", busy, 1'b1);
        while (done !== 1'b1)
        begin
            if (cycles == MAX_WAIT)
            begin
                $display("timeout, no done within %0d cycles", MAX_WAIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
            @(negedge CLK);
            wr = 1'b0;
            rd = 1'b0;
            cycles++;
            if ((done !== 1'b1) && busy && (cycles == stray_at))
            begin
                req = 19'($urandom);  // must be dropped
                if ($urandom % 2)
                    wr = 1'b1;
                else
                    rd = 1'b1;
            end
        end
        res = result;
    endtask

    // nothing may follow the done
    task automatic check_idle();
        repeat (4)
        begin
            @(negedge CLK);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
            check_bit("sda_oe", sda_oe, 1'b0);
        end
    endtask

    initial
    begin
        int             wr_left;
        int             rd_left;
        logic           is_read;
        logic           no_ack;
        logic           recheck;
        eeprom_addr_t   addr;
        eeprom_addr_t   last_wr;
        eeprom_addr_t   recheck_addr;
        logic [7:0]     data;
        eeprom_result_t res;
        eeprom_result_t exp_res;

        void'($urandom(32'h6fb1_f3ec));
        CLK    = 1'b0;
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        req    = '0;
        absent = 1'b0;

        repeat (10)
        begin
            @(negedge CLK);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
            check_bit("sda_oe", sda_oe, 1'b0);
            check_bit("scl", scl, 1'b1);
        end
        RESET = 1'b0;
        @(negedge CLK);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("sda_oe", sda_oe, 1'b0);
        check_bit("scl", scl, 1'b1);

        for (int a = 0; a < 2048; a++)
            ref_mem[a] = eeprom_model_i.mem[a];

        wr_left = N_WRITES;
        rd_left = N_READS;
        recheck = 1'b0;
        last_wr = '0;
        recheck_addr = '0;
        while ((wr_left + rd_left) > 0)
        begin
            no_ack = (($urandom % 8) == 0);
            if (recheck && (rd_left > 0))
            begin
                is_read = 1'b1;   // aborted write left memory alone
                addr    = recheck_addr;
                no_ack  = 1'b0;
                recheck = 1'b0;
            end
            else if ((rd_left == 0) || ((wr_left > 0) && ($urandom % 2)))
            begin
                is_read = 1'b0;
                addr    = 11'($urandom);
            end
            else
            begin
                is_read = 1'b1;
                if ((rd_left % 3) == 0)
                    addr = last_wr;
                else
                    addr = {3'(rd_left), 8'($urandom)};  // walks every page
            end
            data = 8'($urandom);

            run_request(is_read, addr, data, no_ack, res);
            exp_res.nack = no_ack;
            exp_res.data = ref_mem[addr];
            check_result(res, exp_res, is_read && !no_ack);

            if (!is_read && !no_ack)
            begin
                ref_mem[addr] = data;
                last_wr       = addr;
            end
            else if (!is_read)
            begin
                recheck      = 1'b1;
                recheck_addr = addr;
            end
            if (is_read)
                rd_left--;
            else
                wr_left--;
            check_idle();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
eeprom_pkg.sv
i2c_clock_gen.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
